// File: src/aes_bus_pkg.sv
// Bus and block widths, word and block types, address map, access regions and HTRANS codes
package aes_bus_pkg;

	localparam int WORD_W = 32;
	localparam int BLOCK_W = 128;
	localparam int WORDS_PER_BLOCK = BLOCK_W / WORD_W;

	typedef logic [WORD_W-1:0] word_t;
	// Word 0 sits in bits 127:96
	typedef logic [BLOCK_W-1:0] block_t;
	typedef logic [$clog2(WORDS_PER_BLOCK)-1:0] word_index_t;

	typedef enum logic [2:0] {
		REGION_STATUS,
		REGION_ENCRYPT,
		REGION_DECRYPT,
		REGION_KEY,
		REGION_DATA,
		REGION_TX,
		REGION_NONE
	} ahb_region_t;

	localparam logic [31:0] ADDR_STATUS = 32'h0000_0000;
	localparam logic [31:0] ADDR_ENCRYPT = 32'h0000_0004;
	localparam logic [31:0] ADDR_DECRYPT = 32'h0000_0008;
	localparam logic [31:0] KEY_BASE = 32'h0000_0010;
	localparam logic [31:0] DATA_BASE = 32'h0000_0040;
	localparam logic [31:0] TX_BASE = 32'h0000_0080;

	localparam logic [1:0] HTRANS_IDLE = 2'b00;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ = 2'b11;

endpackage

// File: src/bus_access_if.sv
// Decoded bus access handed from the AHB decoder to the block assembler and register block
`timescale 1ns/10ps

interface bus_access_if import aes_bus_pkg::*;
();
	// Read strobe is in the address phase, write strobe in the data phase
	logic rd_strobe;
	logic wr_strobe;
	ahb_region_t region;
	word_index_t word_index;
	word_t wdata;

	modport master
	(
		output rd_strobe,
		output wr_strobe,
		output region,
		output word_index,
		output wdata
	);

	modport consumer
	(
		input rd_strobe,
		input wr_strobe,
		input region,
		input word_index,
		input wdata
	);

endinterface

// File: src/block_fifo.sv
// Synchronous first-word-fall-through FIFO of 128-bit blocks with full and empty flags
`timescale 1ns/10ps

module block_fifo import aes_bus_pkg::*;
#(
	parameter int DEPTH = 4
)
(
	input logic tb_HCLK,
	input logic reset,
	input logic push,
	input block_t push_data,
	input logic pop,
	output block_t head,
	output logic full,
	output logic empty
);
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);
	localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);
	localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(DEPTH);

	block_t mem [DEPTH];
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [CNT_W-1:0] count;
	logic do_push;
	logic do_pop;

	// Push into a full FIFO is dropped, pop of an empty one ignored
	assign do_push = push && !full;
	assign do_pop = pop && !empty;

	always_ff @(posedge tb_HCLK)
	begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

	always_ff @(posedge tb_HCLK)
	begin
		if (reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign head = mem[rd_ptr];
	assign full = (count == FULL_COUNT);
	assign empty = (count == '0);

endmodule

// File: src/ahb_slave_decode.sv
// AHB-Lite address decode, data-phase access register and two-cycle ERROR response
`timescale 1ns/10ps

module ahb_slave_decode import aes_bus_pkg::*;
(
	input logic tb_HCLK,
	input logic reset,
	input logic hsel,
	input logic [31:0] haddr,
	input logic [1:0] htrans,
	input logic hwrite,
	input word_t hwdata,
	input logic tx_fifo_empty,
	output logic hready,
	output logic hresp,
	bus_access_if.master acc
);
	typedef enum logic [1:0] {RESP_OKAY, RESP_ERR_FIRST, RESP_ERR_SECOND} resp_state_t;

	resp_state_t state;
	resp_state_t next_state;
	ahb_region_t addr_region;
	ahb_region_t dp_region;
	word_index_t dp_index;
	logic selected;
	logic accepted;
	logic legal;
	logic dp_write;

	always_comb
	begin
		addr_region = REGION_NONE;
		if (haddr[31:2] == ADDR_STATUS[31:2])
			addr_region = REGION_STATUS;
		else if (haddr[31:2] == ADDR_ENCRYPT[31:2])
			addr_region = REGION_ENCRYPT;
		else if (haddr[31:2] == ADDR_DECRYPT[31:2])
			addr_region = REGION_DECRYPT;
		else if (haddr[31:4] == KEY_BASE[31:4])
			addr_region = REGION_KEY;
		else if (haddr[31:6] == DATA_BASE[31:6])
			addr_region = REGION_DATA;
		else if (haddr[31:7] == TX_BASE[31:7])
			addr_region = REGION_TX;
	end

	// Direction check, plus no reads from an empty transmit FIFO
	always_comb
	begin
		case (addr_region)
			REGION_STATUS: legal = !hwrite;
			REGION_ENCRYPT, REGION_DECRYPT, REGION_KEY, REGION_DATA: legal = hwrite;
			REGION_TX: legal = !hwrite && !tx_fifo_empty;
			default: legal = 1'b0;
		endcase
	end

	assign selected = hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ);
	// Nothing is taken while hready is low
	assign accepted = selected && (state != RESP_ERR_FIRST);

	always_comb
	begin
		if (accepted && !legal)
			next_state = RESP_ERR_FIRST;
		else if (state == RESP_ERR_FIRST)
			next_state = RESP_ERR_SECOND;
		else
			next_state = RESP_OKAY;
	end

	always_ff @(posedge tb_HCLK)
	begin
		if (reset)
		begin
			state <= RESP_OKAY;
			dp_write <= 1'b0;
		end
		else
		begin
			state <= next_state;
			dp_write <= accepted && legal && hwrite;
		end
	end

	always_ff @(posedge tb_HCLK)
	begin
		dp_region <= addr_region;
		dp_index <= haddr[3:2];
	end

	assign hready = (state != RESP_ERR_FIRST);
	assign hresp = (state != RESP_OKAY);

	assign acc.rd_strobe = accepted && legal && !hwrite;
	assign acc.wr_strobe = dp_write;
	// A write data phase owns region and index, reads use the live address
	assign acc.region = dp_write ? dp_region : addr_region;
	assign acc.word_index = dp_write ? dp_index : haddr[3:2];
	assign acc.wdata = hwdata;

endmodule

// File: src/block_assembler.sv
// Collects four key or data words into one block and pushes it into the receive FIFO
`timescale 1ns/10ps

module block_assembler import aes_bus_pkg::*;
(
	input logic tb_HCLK,
	input logic reset,
	bus_access_if.consumer acc,
	output logic push,
	output block_t block
);
	localparam word_index_t LAST_INDEX = word_index_t'(WORDS_PER_BLOCK - 1);

	// The last word goes straight through, only the first three are held
	word_t words_q [WORDS_PER_BLOCK-1];
	logic is_block_write;

	assign is_block_write = acc.wr_strobe
		&& (acc.region == REGION_KEY || acc.region == REGION_DATA);

	always_ff @(posedge tb_HCLK)
	begin
		if (reset)
		begin
			for (int i = 0; i < WORDS_PER_BLOCK - 1; i++)
				words_q[i] <= '0;
		end
		else if (is_block_write && acc.word_index != LAST_INDEX)
			words_q[acc.word_index] <= acc.wdata;
	end

	always_comb
	begin
		for (int i = 0; i < WORDS_PER_BLOCK - 1; i++)
			block[BLOCK_W-1-i*WORD_W -: WORD_W] = words_q[i];
		block[WORD_W-1:0] = acc.wdata;
	end

	assign push = is_block_write && (acc.word_index == LAST_INDEX);

endmodule

// File: src/slave_regs.sv
// Status and transmit read data, encrypt and decrypt command pulses, transmit FIFO pop
`timescale 1ns/10ps

module slave_regs import aes_bus_pkg::*;
(
	input logic tb_HCLK,
	input logic reset,
	input logic [3:0] status,
	input block_t tx_head,
	input logic rcv_full,
	input logic rcv_empty,
	input logic tx_full,
	input logic tx_empty,
	bus_access_if.consumer acc,
	output word_t hrdata,
	output logic tx_pop,
	output logic is_encrypt_pulse,
	output logic is_decrypt_pulse
);
	localparam word_index_t LAST_INDEX = word_index_t'(WORDS_PER_BLOCK - 1);

	word_t tx_word;
	word_t status_word;

	// Word 0 of the head block is the high word
	assign tx_word = tx_head[BLOCK_W-1-WORD_W*int'(acc.word_index) -: WORD_W];

	// Bits 7:4 are rcv_empty, rcv_full, tx_empty, tx_full from the top down
	assign status_word = {{(WORD_W-8){1'b0}}, rcv_empty, rcv_full, tx_empty, tx_full, status};

	always_ff @(posedge tb_HCLK)
	begin
		if (reset)
			hrdata <= '0;
		else if (acc.rd_strobe)
		begin
			case (acc.region)
				REGION_STATUS: hrdata <= status_word;
				REGION_TX: hrdata <= tx_word;
				default: hrdata <= '0;
			endcase
		end
	end

	// Last word of a block read releases the head
	assign tx_pop = acc.rd_strobe && (acc.region == REGION_TX) && (acc.word_index == LAST_INDEX);

	assign is_encrypt_pulse = acc.wr_strobe && (acc.region == REGION_ENCRYPT);
	assign is_decrypt_pulse = acc.wr_strobe && (acc.region == REGION_DECRYPT);

endmodule

// File: src/ahb_block_port.sv
// AHB-Lite slave top level joining the decoder, block assembler, register block and two block FIFOs
`timescale 1ns/10ps

module ahb_block_port import aes_bus_pkg::*;
#(
	parameter int RCV_DEPTH = 4,
	parameter int TX_DEPTH = 4
)
(
	input logic tb_HCLK,
	input logic reset,
	input logic hsel,
	input logic [31:0] haddr,
	input logic [1:0] htrans,
	input logic hwrite,
	input word_t hwdata,
	input logic [3:0] status,
	input block_t data_in,
	input logic tx_enq,
	input logic rcv_deq,
	output word_t hrdata,
	output logic hready,
	output logic hresp,
	output logic is_encrypt_pulse,
	output logic is_decrypt_pulse,
	output block_t rcv_fifo_out,
	output logic tx_fifo_full,
	output logic tx_fifo_empty,
	output logic rcv_fifo_full,
	output logic rcv_fifo_empty
);
	bus_access_if acc_if();

	logic rcv_push;
	block_t rcv_block;
	logic tx_pop;
	block_t tx_head;

	ahb_slave_decode decode_i
	(
		.tb_HCLK(tb_HCLK),
		.reset(reset),
		.hsel(hsel),
		.haddr(haddr),
		.htrans(htrans),
		.hwrite(hwrite),
		.hwdata(hwdata),
		.tx_fifo_empty(tx_fifo_empty),
		.hready(hready),
		.hresp(hresp),
		.acc(acc_if.master)
	);

	block_assembler assembler_i
	(
		.tb_HCLK(tb_HCLK),
		.reset(reset),
		.acc(acc_if.consumer),
		.push(rcv_push),
		.block(rcv_block)
	);

	slave_regs regs_i
	(
		.tb_HCLK(tb_HCLK),
		.reset(reset),
		.status(status),
		.tx_head(tx_head),
		.rcv_full(rcv_fifo_full),
		.rcv_empty(rcv_fifo_empty),
		.tx_full(tx_fifo_full),
		.tx_empty(tx_fifo_empty),
		.acc(acc_if.consumer),
		.hrdata(hrdata),
		.tx_pop(tx_pop),
		.is_encrypt_pulse(is_encrypt_pulse),
		.is_decrypt_pulse(is_decrypt_pulse)
	);

	// Blocks from the master towards the cipher core
	block_fifo #(.DEPTH(RCV_DEPTH)) rcv_fifo_i
	(
		.tb_HCLK(tb_HCLK),
		.reset(reset),
		.push(rcv_push),
		.push_data(rcv_block),
		.pop(rcv_deq),
		.head(rcv_fifo_out),
		.full(rcv_fifo_full),
		.empty(rcv_fifo_empty)
	);

	// Result blocks from the core back to the master
	block_fifo #(.DEPTH(TX_DEPTH)) tx_fifo_i
	(
		.tb_HCLK(tb_HCLK),
		.reset(reset),
		.push(tx_enq),
		.push_data(data_in),
		.pop(tx_pop),
		.head(tx_head),
		.full(tx_fifo_full),
		.empty(tx_fifo_empty)
	);

endmodule

// File: testbench/tb_clock_gen.sv
// Testbench clock and synchronous reset generator
`timescale 1ns/10ps

module tb_clock_gen
#(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 3
)
(
	output logic tb_HCLK,
	output logic reset
);
	initial
	begin
		tb_HCLK = 1'b0;
		forever
			#(PERIOD / 2) tb_HCLK = ~tb_HCLK;
	end

	// Reset covers the first rising edges, released just after the last one
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge tb_HCLK);
		#1;
		reset = 1'b0;
	end

endmodule

// File: testbench/tb_checker.sv
// Cycle model of the AHB block port, reference decode functions and per-cycle output comparison
`timescale 1ns/10ps

module tb_checker import aes_bus_pkg::*;
#(
	parameter int RCV_DEPTH = 4,
	parameter int TX_DEPTH = 4
)
(
	input logic tb_HCLK,
	input logic reset,
	input logic hsel,
	input logic [31:0] haddr,
	input logic [1:0] htrans,
	input logic hwrite,
	input word_t hwdata,
	input logic [3:0] status,
	input block_t data_in,
	input logic tx_enq,
	input logic rcv_deq,
	input word_t hrdata,
	input logic hready,
	input logic hresp,
	input logic is_encrypt_pulse,
	input logic is_decrypt_pulse,
	input block_t rcv_fifo_out,
	input logic tx_fifo_full,
	input logic tx_fifo_empty,
	input logic rcv_fifo_full,
	input logic rcv_fifo_empty,
	output int errors
);
	block_t rcv_q[$];
	block_t tx_q[$];
	word_t words [3];
	word_t hrdata_exp;
	int err_state;
	logic dp_write;
	ahb_region_t dp_region;
	logic [1:0] dp_index;
	logic model_valid = 1'b0;
	int error_count = 0;

	assign errors = error_count;

	// Target of an access, REGION_NONE for anything illegal
	function automatic ahb_region_t classify(logic [31:0] addr, logic write, logic tx_empty);
		logic [31:0] a;
		a = {addr[31:2], 2'b00};
		if (a == ADDR_STATUS)
			return write ? REGION_NONE : REGION_STATUS;
		if (a == ADDR_ENCRYPT)
			return write ? REGION_ENCRYPT : REGION_NONE;
		if (a == ADDR_DECRYPT)
			return write ? REGION_DECRYPT : REGION_NONE;
		if (a >= KEY_BASE && a < KEY_BASE + 32'h10)
			return write ? REGION_KEY : REGION_NONE;
		if (a >= DATA_BASE && a < DATA_BASE + 32'h40)
			return write ? REGION_DATA : REGION_NONE;
		if (a >= TX_BASE && a < TX_BASE + 32'h80)
			return (write || tx_empty) ? REGION_NONE : REGION_TX;
		return REGION_NONE;
	endfunction

	// Word 0 is the most significant word of a block
	function automatic word_t block_word(block_t blk, int idx);
		return blk[127 - 32 * idx -: 32];
	endfunction

	function automatic word_t status_word(logic [3:0] st, int rcv_n, int tx_n);
		return {24'h0, rcv_n == 0, rcv_n == RCV_DEPTH, tx_n == 0, tx_n == TX_DEPTH, st};
	endfunction

	task automatic compare_value(string name, logic [127:0] expected, logic [127:0] actual);
		if (actual !== expected)
		begin
			error_count++;
			$display("Error at time %0t: %s expected %0h, got %0h", $time, name, expected,
				actual);
		end
	endtask

	// Outputs are compared mid-cycle, then the model takes the inputs of the coming edge
	always @(negedge tb_HCLK)
	begin : model_step
		ahb_region_t region;
		logic accepted;
		logic rcv_push_ok;
		logic rcv_pop_ok;
		logic tx_push_ok;
		logic tx_pop;
		block_t blk;

		if (model_valid)
		begin
			compare_value("hready", err_state != 1, hready);
			compare_value("hresp", err_state != 0, hresp);
			compare_value("hrdata", hrdata_exp, hrdata);
			compare_value("is_encrypt_pulse", dp_write && dp_region == REGION_ENCRYPT,
				is_encrypt_pulse);
			compare_value("is_decrypt_pulse", dp_write && dp_region == REGION_DECRYPT,
				is_decrypt_pulse);
			compare_value("rcv_fifo_empty", rcv_q.size() == 0, rcv_fifo_empty);
			compare_value("rcv_fifo_full", rcv_q.size() == RCV_DEPTH, rcv_fifo_full);
			compare_value("tx_fifo_empty", tx_q.size() == 0, tx_fifo_empty);
			compare_value("tx_fifo_full", tx_q.size() == TX_DEPTH, tx_fifo_full);
			if (rcv_q.size() != 0)
				compare_value("rcv_fifo_out", rcv_q[0], rcv_fifo_out);
		end

		if (reset)
		begin
			rcv_q.delete();
			tx_q.delete();
			for (int i = 0; i < 3; i++)
				words[i] = '0;
			err_state = 0;
			dp_write = 1'b0;
			dp_region = REGION_NONE;
			dp_index = '0;
			hrdata_exp = '0;
			model_valid = 1'b1;
		end
		else
		begin
			accepted = hsel && (htrans == HTRANS_NONSEQ || htrans == HTRANS_SEQ)
				&& err_state != 1;
			region = classify(haddr, hwrite, tx_q.size() == 0);
			rcv_push_ok = 1'b0;
			blk = '0;
			if (dp_write && (dp_region == REGION_KEY || dp_region == REGION_DATA))
			begin
				if (dp_index == 2'd3)
				begin
					blk = {words[0], words[1], words[2], hwdata};
					rcv_push_ok = rcv_q.size() < RCV_DEPTH;
				end
				else
					words[dp_index] = hwdata;
			end
			rcv_pop_ok = rcv_deq && rcv_q.size() != 0;
			tx_push_ok = tx_enq && tx_q.size() < TX_DEPTH;
			tx_pop = 1'b0;
			if (accepted && region == REGION_STATUS)
				hrdata_exp = status_word(status, rcv_q.size(), tx_q.size());
			else if (accepted && region == REGION_TX)
			begin
				hrdata_exp = block_word(tx_q[0], haddr[3:2]);
				tx_pop = (haddr[3:2] == 2'd3);
			end
			if (rcv_pop_ok)
				void'(rcv_q.pop_front());
			if (rcv_push_ok)
				rcv_q.push_back(blk);
			if (tx_pop)
				void'(tx_q.pop_front());
			if (tx_push_ok)
				tx_q.push_back(data_in);
			// Error response runs OKAY, first cycle, second cycle
			if (accepted && region == REGION_NONE)
				err_state = 1;
			else if (err_state == 1)
				err_state = 2;
			else
				err_state = 0;
			dp_write = accepted && region != REGION_NONE && hwrite;
			dp_region = region;
			dp_index = haddr[3:2];
		end
	end

endmodule

// File: testbench/tb_ahb_block_port.sv
// Testbench top with the DUT, bus and FIFO stimulus tasks, block data generator and watchdog
`timescale 1ns/10ps

module tb_ahb_block_port import aes_bus_pkg::*;
();
	localparam int RCV_DEPTH = 4;
	localparam int TX_DEPTH = 4;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 1;
	// Clock cycles taken by the sequence in the stimulus process
	localparam int SCHEDULED_CYCLES = 69 + 5 * (RCV_DEPTH + 1) + 2 * RCV_DEPTH
		+ 2 * (TX_DEPTH + 1) + 5 * TX_DEPTH;

	logic tb_HCLK;
	logic reset;
	logic hsel;
	logic [31:0] haddr;
	logic [1:0] htrans;
	logic hwrite;
	word_t hwdata;
	logic [3:0] status;
	block_t data_in;
	logic tx_enq;
	logic rcv_deq;
	word_t hrdata;
	logic hready;
	logic hresp;
	logic is_encrypt_pulse;
	logic is_decrypt_pulse;
	block_t rcv_fifo_out;
	logic tx_fifo_full;
	logic tx_fifo_empty;
	logic rcv_fifo_full;
	logic rcv_fifo_empty;
	int errors;
	int stall_errors;
	word_t lcg_state = 32'd88060;

	tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clock_i
	(
		.tb_HCLK(tb_HCLK),
		.reset(reset)
	);

	ahb_block_port #(.RCV_DEPTH(RCV_DEPTH), .TX_DEPTH(TX_DEPTH)) dut_i (.*);

	tb_checker #(.RCV_DEPTH(RCV_DEPTH), .TX_DEPTH(TX_DEPTH)) check_i (.*);

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic block_t random_block();
		block_t b;
		for (int i = 0; i < 4; i++)
			b[127 - 32 * i -: 32] = lcg_next();
		return b;
	endfunction

	// Data phase ends on the first cycle with hready high
	task automatic wait_ready();
		int cycles;
		cycles = 0;
		@(negedge tb_HCLK);
		while (!hready && cycles < 8)
		begin
			cycles++;
			@(negedge tb_HCLK);
		end
		if (!hready)
		begin
			stall_errors++;
			$display("Slave held hready low for more than 8 cycles at time %0t", $time);
		end
	endtask

	task automatic bus_burst(input logic [31:0] base, input logic write, input block_t b);
		for (int i = 0; i < 4; i++)
		begin
			@(posedge tb_HCLK);
			#DRIVE_DELAY;
			hsel = 1'b1;
			htrans = (i == 0) ? HTRANS_NONSEQ : HTRANS_SEQ;
			hwrite = write;
			haddr = base + 32'(4 * i);
			if (i > 0)
				hwdata = b[127 - 32 * (i - 1) -: 32];
		end
		@(posedge tb_HCLK);
		#DRIVE_DELAY;
		hsel = 1'b0;
		htrans = HTRANS_IDLE;
		hwdata = b[31:0];
		wait_ready();
	endtask

	task automatic single_access(input logic [31:0] addr, input logic write, input word_t wdata);
		@(posedge tb_HCLK);
		#DRIVE_DELAY;
		hsel = 1'b1;
		htrans = HTRANS_NONSEQ;
		hwrite = write;
		haddr = addr;
		@(posedge tb_HCLK);
		#DRIVE_DELAY;
		hsel = 1'b0;
		htrans = HTRANS_IDLE;
		hwdata = wdata;
		wait_ready();
	endtask

	task automatic enqueue_tx(input block_t b);
		@(posedge tb_HCLK);
		#DRIVE_DELAY;
		data_in = b;
		tx_enq = 1'b1;
		@(posedge tb_HCLK);
		#DRIVE_DELAY;
		tx_enq = 1'b0;
	endtask

	task automatic dequeue_rcv();
		@(posedge tb_HCLK);
		#DRIVE_DELAY;
		rcv_deq = 1'b1;
		@(posedge tb_HCLK);
		#DRIVE_DELAY;
		rcv_deq = 1'b0;
	endtask

	initial
	begin
		hsel = 1'b0;
		haddr = '0;
		htrans = HTRANS_IDLE;
		hwrite = 1'b0;
		hwdata = '0;
		status = 4'h0;
		data_in = '0;
		tx_enq = 1'b0;
		rcv_deq = 1'b0;
		stall_errors = 0;
		@(negedge reset);
		@(posedge tb_HCLK);

		// Key block then data block, taken out in write order
		bus_burst(KEY_BASE, 1'b1, random_block());
		bus_burst(DATA_BASE + 32'h20, 1'b1, random_block());
		dequeue_rcv();
		dequeue_rcv();
		// One block more than the receive FIFO holds
		for (int n = 0; n <= RCV_DEPTH; n++)
			bus_burst(DATA_BASE + 32'(16 * (n % 4)), 1'b1, random_block());
		// Status flags with only the receive FIFO full
		status = 4'(lcg_next());
		single_access(ADDR_STATUS, 1'b0, '0);
		for (int n = 0; n < RCV_DEPTH; n++)
			dequeue_rcv();

		for (int n = 0; n <= TX_DEPTH; n++)
			enqueue_tx(random_block());
		// Status flags with only the transmit FIFO full
		status = 4'(lcg_next());
		single_access(ADDR_STATUS, 1'b0, '0);
		for (int n = 0; n < TX_DEPTH; n++)
			bus_burst(TX_BASE, 1'b0, '0);

		// Illegal accesses with a block waiting in the receive FIFO
		bus_burst(KEY_BASE, 1'b1, random_block());
		single_access(32'h0000_0128, 1'b1, lcg_next());
		single_access(ADDR_ENCRYPT, 1'b0, '0);
		single_access(ADDR_STATUS, 1'b1, lcg_next());
		single_access(TX_BASE, 1'b0, '0);

		single_access(ADDR_ENCRYPT, 1'b1, lcg_next());
		single_access(ADDR_DECRYPT, 1'b1, lcg_next());
		enqueue_tx(random_block());
		status = 4'(lcg_next());
		single_access(ADDR_STATUS, 1'b0, '0);
		bus_burst(TX_BASE, 1'b0, '0);
		dequeue_rcv();
		status = 4'(lcg_next());
		single_access(ADDR_STATUS, 1'b0, '0);

		repeat (3) @(posedge tb_HCLK);
		$display("Checks finished with %0d value errors and %0d handshake errors", errors,
			stall_errors);
		if (errors + stall_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

	initial
	begin
		#((SCHEDULED_CYCLES + 200) * CLK_PERIOD);
		$display("Timeout: the test sequence did not end within %0d clock cycles",
			SCHEDULED_CYCLES + 200);
		$display("Checks failed");
		$finish;
	end

endmodule

// File: all.f
src/aes_bus_pkg.sv
src/bus_access_if.sv
src/block_fifo.sv
src/ahb_slave_decode.sv
src/block_assembler.sv
src/slave_regs.sv
src/ahb_block_port.sv
testbench/tb_clock_gen.sv
testbench/tb_checker.sv
testbench/tb_ahb_block_port.sv

// File: Bender.yml
package:
  name: ahb_block_port

sources:
  - src/aes_bus_pkg.sv
  - src/bus_access_if.sv
  - src/block_fifo.sv
  - src/ahb_slave_decode.sv
  - src/block_assembler.sv
  - src/slave_regs.sv
  - src/ahb_block_port.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/tb_checker.sv
      - testbench/tb_ahb_block_port.sv
